// File: ieu_pkg.sv
// integer execution unit package with widths, types, ALU functions, opcodes and stage bundles.
package ieu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int TAG_WIDTH  = 4;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [4:0]            shamt_t;
    typedef logic [31:0]           instr_t;

    // compares return 1 or 0 in bit 0.
    typedef enum logic [3:0] {
        ALU_FUNC_ADD,
        ALU_FUNC_SUB,
        ALU_FUNC_AND,
        ALU_FUNC_OR,
        ALU_FUNC_XOR,
        ALU_FUNC_SLL,
        ALU_FUNC_SRL,
        ALU_FUNC_SRA,
        ALU_FUNC_EQ,
        ALU_FUNC_NE,
        ALU_FUNC_LT,
        ALU_FUNC_LTU,
        ALU_FUNC_GE,
        ALU_FUNC_GEU
    } alu_func_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        alu_func_t alu_func;
        data_t     src_a;
        data_t     src_b;
        addr_t     iaddr;
        data_t     imm_b;
        shamt_t    shamt;
        tag_t      tag;
        reg_idx_t  rd;
        logic      rd_we;
        logic      jmp;
        logic      br;
        logic      valid;
    } dec_op_t;

    typedef struct packed {
        data_t    data;
        addr_t    addr;
        tag_t     tag;
        reg_idx_t rd;
        logic     rd_we;
        logic     redirect;
        logic     valid;
    } ex_res_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     rd_we;
        data_t    data;
        tag_t     tag;
        logic     redirect;
        addr_t    addr;
    } wb_t;

endpackage

// File: ieu_regfile.sv
// integer register file with 32 words, two read ports, one write port and x0 tied to zero.
`timescale 1ns/100ps

module ieu_regfile (
    input  logic              clk,
    input  logic              i_rst,

    input  ieu_pkg::reg_idx_t i_raddr_a,
    input  ieu_pkg::reg_idx_t i_raddr_b,
    output ieu_pkg::data_t    o_rdata_a,
    output ieu_pkg::data_t    o_rdata_b,

    input  ieu_pkg::wb_t      i_wb
);

    import ieu_pkg::*;

    data_t regs [32];
    logic  wr_en;

    assign wr_en = i_wb.valid && i_wb.rd_we;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // combinational reads.
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

// File: ieu_decode.sv
// decode stage of the integer execution unit with field split, bypass and the decode register.
`timescale 1ns/100ps

module ieu_decode (
    input  logic              clk,
    input  logic              i_rst,

    input  logic              i_valid,
    input  ieu_pkg::instr_t   i_instr,
    input  ieu_pkg::addr_t    i_iaddr,
    input  ieu_pkg::tag_t     i_tag,

    output ieu_pkg::reg_idx_t o_raddr_a,
    output ieu_pkg::reg_idx_t o_raddr_b,
    input  ieu_pkg::data_t    i_rdata_a,
    input  ieu_pkg::data_t    i_rdata_b,

    input  ieu_pkg::ex_res_t  i_ex,
    input  ieu_pkg::wb_t      i_wb,

    output ieu_pkg::dec_op_t  o_op
);

    import ieu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    data_t      imm_i;
    data_t      imm_u;
    data_t      imm_j;
    data_t      imm_b;
    data_t      rs1_data;
    data_t      rs2_data;
    alu_func_t  arith_func;
    alu_func_t  br_func;
    logic       flush;
    dec_op_t    op_d;
    dec_op_t    op_q;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

    assign o_raddr_a = rs1;
    assign o_raddr_b = rs2;

    // younger execute result wins over the retiring one.
    function automatic data_t fwd(reg_idx_t idx, data_t rf_data, ex_res_t ex, wb_t wb);
        data_t val;
        val = rf_data;
        if (idx != '0) begin
            if (ex.valid && ex.rd_we && (ex.rd == idx)) begin
                val = ex.data;
            end else if (wb.valid && wb.rd_we && (wb.rd == idx)) begin
                val = wb.data;
            end
        end
        return val;
    endfunction

    assign rs1_data = fwd(rs1, i_rdata_a, i_ex, i_wb);
    assign rs2_data = fwd(rs2, i_rdata_b, i_ex, i_wb);

    always_comb begin
        case (funct3)
            3'b000:  arith_func = (opcode == OPC_OP && funct7[5]) ? ALU_FUNC_SUB : ALU_FUNC_ADD;
            3'b001:  arith_func = ALU_FUNC_SLL;
            3'b010:  arith_func = ALU_FUNC_LT;
            3'b011:  arith_func = ALU_FUNC_LTU;
            3'b100:  arith_func = ALU_FUNC_XOR;
            3'b101:  arith_func = funct7[5] ? ALU_FUNC_SRA : ALU_FUNC_SRL;
            3'b110:  arith_func = ALU_FUNC_OR;
            default: arith_func = ALU_FUNC_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_func = ALU_FUNC_EQ;
            3'b001:  br_func = ALU_FUNC_NE;
            3'b100:  br_func = ALU_FUNC_LT;
            3'b101:  br_func = ALU_FUNC_GE;
            3'b110:  br_func = ALU_FUNC_LTU;
            default: br_func = ALU_FUNC_GEU;
        endcase
    end

    always_comb begin
        op_d          = '0;
        op_d.alu_func = ALU_FUNC_ADD;
        op_d.src_a    = rs1_data;
        op_d.src_b    = rs2_data;
        op_d.iaddr    = i_iaddr;
        op_d.imm_b    = imm_b;
        op_d.shamt    = rs2_data[4:0];
        op_d.tag      = i_tag;
        op_d.rd       = i_instr[11:7];
        op_d.valid    = i_valid;
        case (opcode)
            OPC_OP: begin
                op_d.alu_func = arith_func;
                op_d.rd_we    = 1'b1;
            end
            OPC_OP_IMM: begin
                op_d.alu_func = arith_func;
                op_d.src_b    = imm_i;
                op_d.shamt    = shamt_t'(i_instr[24:20]);
                op_d.rd_we    = 1'b1;
            end
            OPC_LUI: begin
                op_d.src_a = '0;
                op_d.src_b = imm_u;
                op_d.rd_we = 1'b1;
            end
            OPC_AUIPC: begin
                op_d.src_a = data_t'(i_iaddr);
                op_d.src_b = imm_u;
                op_d.rd_we = 1'b1;
            end
            OPC_JAL: begin
                op_d.src_a = data_t'(i_iaddr);
                op_d.src_b = imm_j;
                op_d.jmp   = 1'b1;
                op_d.rd_we = 1'b1;
            end
            OPC_JALR: begin
                op_d.src_b = imm_i;
                op_d.jmp   = 1'b1;
                op_d.rd_we = 1'b1;
            end
            OPC_BRANCH: begin
                op_d.alu_func = br_func;
                op_d.br       = 1'b1;
            end
            default: begin
                op_d.rd_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        op_q <= op_d;
        if (i_rst) begin
            op_q.valid <= 1'b0;
        end
    end

    // shadow of a taken branch or jump is squashed.
    assign flush = i_wb.valid && i_wb.redirect;

    always_comb begin
        o_op       = op_q;
        o_op.valid = op_q.valid && !flush;
    end

    // a live jump always kills the slot behind it.
    a_jump_shadow: assert property (@(posedge clk) disable iff (i_rst)
        (o_op.valid && o_op.jmp) |=> !o_op.valid)
        else $error("instruction after a jump was not squashed");

endmodule

// File: ieu_ex.sv
// execute stage of the integer execution unit with the ALU and link, target and redirect logic.
`timescale 1ns/100ps

module ieu_ex (
    input  ieu_pkg::dec_op_t i_op,
    output ieu_pkg::ex_res_t o_res
);

    import ieu_pkg::*;

    data_t                   result;
    logic [2*DATA_WIDTH-1:0] e_src_a;
    logic signed [DATA_WIDTH-1:0] s_src_a;
    logic signed [DATA_WIDTH-1:0] s_src_b;

    // sign extended copy of src_a for arithmetic right shift.
    assign e_src_a = {{DATA_WIDTH{i_op.src_a[DATA_WIDTH-1]}}, i_op.src_a};
    assign s_src_a = i_op.src_a;
    assign s_src_b = i_op.src_b;

    always_comb begin
        case (i_op.alu_func)
            ALU_FUNC_ADD: result = i_op.src_a + i_op.src_b;
            ALU_FUNC_SUB: result = i_op.src_a - i_op.src_b;
            ALU_FUNC_AND: result = i_op.src_a & i_op.src_b;
            ALU_FUNC_OR:  result = i_op.src_a | i_op.src_b;
            ALU_FUNC_XOR: result = i_op.src_a ^ i_op.src_b;
            ALU_FUNC_SLL: result = i_op.src_a << i_op.shamt;
            ALU_FUNC_SRL: result = i_op.src_a >> i_op.shamt;
            ALU_FUNC_SRA: result = data_t'(e_src_a >> i_op.shamt);
            ALU_FUNC_EQ:  result = data_t'(i_op.src_a == i_op.src_b);
            ALU_FUNC_NE:  result = data_t'(i_op.src_a != i_op.src_b);
            ALU_FUNC_LT:  result = data_t'(s_src_a < s_src_b);
            ALU_FUNC_LTU: result = data_t'(i_op.src_a < i_op.src_b);
            ALU_FUNC_GE:  result = data_t'(s_src_a >= s_src_b);
            ALU_FUNC_GEU: result = data_t'(i_op.src_a >= i_op.src_b);
            default:      result = '0;
        endcase
    end

    always_comb begin
        o_res.tag   = i_op.tag;
        o_res.rd    = i_op.rd;
        o_res.rd_we = i_op.rd_we;
        o_res.valid = i_op.valid;
        if (i_op.jmp) begin
            // link address goes to rd and the ALU sum is the target.
            o_res.data     = data_t'(i_op.iaddr + addr_t'(4));
            o_res.addr     = addr_t'(result);
            o_res.redirect = 1'b1;
        end else if (i_op.br) begin
            o_res.data     = result;
            o_res.addr     = i_op.iaddr + addr_t'(i_op.imm_b);
            o_res.redirect = result[0];
        end else begin
            o_res.data     = result;
            o_res.addr     = '0;
            o_res.redirect = 1'b0;
        end
    end

endmodule

// File: ieu_result.sv
// result stage of the integer execution unit that registers the retirement record.
`timescale 1ns/100ps

module ieu_result (
    input  logic             clk,
    input  logic             i_rst,

    input  ieu_pkg::ex_res_t i_res,
    output ieu_pkg::wb_t     o_wb
);

    import ieu_pkg::*;

    wb_t  wb_d;
    logic take;

    // only a live instruction may redirect.
    assign take = i_res.valid && i_res.redirect;

    always_comb begin
        wb_d.valid    = i_res.valid;
        wb_d.rd       = i_res.rd;
        wb_d.rd_we    = i_res.rd_we && (i_res.rd != '0);
        wb_d.data     = i_res.data;
        wb_d.tag      = i_res.tag;
        wb_d.redirect = take;
        wb_d.addr     = take ? i_res.addr : '0;
    end

    always_ff @(posedge clk) begin
        o_wb <= wb_d;
        if (i_rst) begin
            o_wb.valid    <= 1'b0;
            o_wb.redirect <= 1'b0;
        end
    end

    // decode must have squashed the shadow instruction.
    a_shadow_squash: assert property (@(posedge clk) disable iff (i_rst)
        o_wb.redirect |=> !o_wb.valid)
        else $error("instruction after a redirect retired");

endmodule

// File: ieu_top.sv
// integer execution unit top that joins decode, execute, result and the register file.
`timescale 1ns/100ps

module ieu_top (
    input  logic            clk,
    input  logic            i_rst,

    input  logic            i_valid,
    input  ieu_pkg::instr_t i_instr,
    input  ieu_pkg::addr_t  i_iaddr,
    input  ieu_pkg::tag_t   i_tag,

    output ieu_pkg::wb_t    o_wb
);

    import ieu_pkg::*;

    reg_idx_t raddr_a;
    reg_idx_t raddr_b;
    data_t    rdata_a;
    data_t    rdata_b;
    dec_op_t  dec_op;
    ex_res_t  ex_res;
    wb_t      wb;

    assign o_wb = wb;

    ieu_decode ieu_decode_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_iaddr   (i_iaddr),
        .i_tag     (i_tag),
        .o_raddr_a (raddr_a),
        .o_raddr_b (raddr_b),
        .i_rdata_a (rdata_a),
        .i_rdata_b (rdata_b),
        .i_ex      (ex_res),
        .i_wb      (wb),
        .o_op      (dec_op)
    );

    ieu_ex ieu_ex_i (
        .i_op  (dec_op),
        .o_res (ex_res)
    );

    ieu_result ieu_result_i (
        .clk   (clk),
        .i_rst (i_rst),
        .i_res (ex_res),
        .o_wb  (wb)
    );

    ieu_regfile ieu_regfile_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b),
        .i_wb      (wb)
    );

endmodule

// File: ieu_tb.sv
// testbench for the integer execution unit that replays the tests file and checks retirement.
`timescale 1ns/100ps

module ieu_tb;

    import ieu_pkg::*;

    localparam int MAX_TESTS = 128;

    logic   clk;
    logic   rst;
    logic   in_valid;
    instr_t in_instr;
    addr_t  in_iaddr;
    tag_t   in_tag;
    wb_t    wb;

    logic [127:0] t_name [MAX_TESTS];
    logic         t_idle [MAX_TESTS];
    logic [31:0]  t_tag [MAX_TESTS];
    logic [31:0]  t_addr [MAX_TESTS];
    logic [31:0]  t_instr [MAX_TESTS];
    int           t_retire [MAX_TESTS];
    int           t_rd [MAX_TESTS];
    logic [31:0]  t_data [MAX_TESTS];
    int           t_redirect [MAX_TESTS];
    logic [31:0]  t_target [MAX_TESTS];

    int   num_tests;
    int   errors;
    logic loaded;

    ieu_top ieu_top_i (
        .clk     (clk),
        .i_rst   (rst),
        .i_valid (in_valid),
        .i_instr (in_instr),
        .i_iaddr (in_iaddr),
        .i_tag   (in_tag),
        .o_wb    (wb)
    );

    always #50 clk = ~clk;

    task automatic load_tests();
        int          fd;
        int          got;
        string       line;
        logic [127:0] name;
        logic [31:0] tag;
        logic [31:0] addr;
        logic [31:0] instr;
        int          retire;
        int          rd;
        logic [31:0] data;
        int          redirect;
        logic [31:0] target;
        num_tests = 0;
        fd = $fopen("ieu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open ieu_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 0 && line.getc(0) != "#") begin
                got = $sscanf(line, "%s %h %h %h %d %d %h %d %h", name, tag, addr,
                              instr, retire, rd, data, redirect, target);
                if (got == 9) begin
                    t_name[num_tests]     = name;
                    t_idle[num_tests]     = (name == "idle");
                    t_tag[num_tests]      = tag;
                    t_addr[num_tests]     = addr;
                    t_instr[num_tests]    = instr;
                    t_retire[num_tests]   = retire;
                    t_rd[num_tests]       = rd;
                    t_data[num_tests]     = data;
                    t_redirect[num_tests] = redirect;
                    t_target[num_tests]   = target;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("no tests found in ieu_tests.txt");
            errors++;
        end
    endtask

    task automatic compare_value(input logic [127:0] name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %0s %0s expected %h actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    // record for test idx is on o_wb two cycles after it was driven.
    task automatic check_record(input int idx);
        logic [127:0] nm;
        nm = t_name[idx];
        if (t_retire[idx] == 0) begin
            compare_value(nm, "valid", 32'd0, 32'(wb.valid));
            compare_value(nm, "redirect", 32'd0, 32'(wb.redirect));
        end else begin
            compare_value(nm, "valid", 32'd1, 32'(wb.valid));
            compare_value(nm, "tag", 32'(t_tag[idx][TAG_WIDTH-1:0]), 32'(wb.tag));
            compare_value(nm, "rd_we", 32'(t_rd[idx] != 0), 32'(wb.rd_we));
            if (t_rd[idx] != 0) begin
                compare_value(nm, "rd", 32'(t_rd[idx]), 32'(wb.rd));
                compare_value(nm, "data", t_data[idx], wb.data);
            end
            compare_value(nm, "redirect", 32'(t_redirect[idx]), 32'(wb.redirect));
            compare_value(nm, "target", t_target[idx], wb.addr);
        end
    endtask

    task automatic drive_test(input int idx);
        in_valid = !t_idle[idx];
        in_instr = t_instr[idx];
        in_iaddr = t_addr[idx];
        in_tag   = t_tag[idx][TAG_WIDTH-1:0];
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        in_instr = '0;
        in_iaddr = '0;
        in_tag   = '0;
    endtask

    // watchdog sized from the test count.
    initial begin
        wait (loaded);
        #((num_tests + 20) * 100);
        $display("timeout, simulation did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        errors   = 0;
        loaded   = 1'b0;
        drive_idle();
        load_tests();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_tests + 2; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                check_record(i - 2);
            end
            if (i < num_tests) begin
                drive_test(i);
            end else begin
                drive_idle();
            end
        end
        $display("tests: %0d errors: %0d", num_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: ieu_tests.txt
# name tag addr instr retire rd data redirect target
# tag addr instr data target in hex, retire rd redirect in decimal, idle drives no instruction
idle 0 00000000 00000000 0 0 00000000 0 00000000
idle 0 00000000 00000000 0 0 00000000 0 00000000
addi_pos 1 00000100 00500093 1 1 00000005 0 00000000
addi_neg 2 00000104 ffd00113 1 2 fffffffd 0 00000000
add_fwd 3 00000108 002081b3 1 3 00000002 0 00000000
sub 4 0000010c 40208233 1 4 00000008 0 00000000
and 5 00000110 0020f2b3 1 5 00000005 0 00000000
or 6 00000114 0020e333 1 6 fffffffd 0 00000000
xor 7 00000118 0020c3b3 1 7 fffffff8 0 00000000
slt 8 0000011c 00112433 1 8 00000001 0 00000000
sltu 9 00000120 001134b3 1 9 00000000 0 00000000
sll a 00000124 00109533 1 10 000000a0 0 00000000
srai_31 b 00000128 41f15593 1 11 ffffffff 0 00000000
srli_0 c 0000012c 00015613 1 12 fffffffd 0 00000000
srl d 00000130 001156b3 1 13 07ffffff 0 00000000
sra e 00000134 40115733 1 14 ffffffff 0 00000000
slli_31 f 00000138 01f09793 1 15 80000000 0 00000000
lui 0 0000013c 12345837 1 16 12345000 0 00000000
auipc 1 00000140 00001897 1 17 00001140 0 00000000
addi_x0 2 00000144 00708013 1 0 00000000 0 00000000
add_x0 3 00000148 00000933 1 18 00000000 0 00000000
idle 0 00000000 00000000 0 0 00000000 0 00000000
addi_rf 4 0000014c 00118993 1 19 00000003 0 00000000
beq_t 5 00000150 00108463 1 0 00000000 1 00000158
beq_shadow 6 00000154 06300a13 0 0 00000000 0 00000000
beq_nt 7 00000158 00208463 1 0 00000000 0 00000000
bne_t 8 0000015c 00209463 1 0 00000000 1 00000164
bne_shadow 9 00000160 06300a13 0 0 00000000 0 00000000
bne_nt a 00000164 00109463 1 0 00000000 0 00000000
blt_t b 00000168 00114463 1 0 00000000 1 00000170
blt_shadow c 0000016c 06300a13 0 0 00000000 0 00000000
blt_nt d 00000170 0020c463 1 0 00000000 0 00000000
bge_t e 00000174 0020d463 1 0 00000000 1 0000017c
bge_shadow f 00000178 06300a13 0 0 00000000 0 00000000
bge_nt 0 0000017c 00115463 1 0 00000000 0 00000000
bltu_t 1 00000180 0020e463 1 0 00000000 1 00000188
bltu_shadow 2 00000184 06300a13 0 0 00000000 0 00000000
bltu_nt 3 00000188 00116463 1 0 00000000 0 00000000
bgeu_t 4 0000018c 00117463 1 0 00000000 1 00000194
bgeu_shadow 5 00000190 06300a13 0 0 00000000 0 00000000
bgeu_nt 6 00000194 0020f463 1 0 00000000 0 00000000
read_x20 7 00000198 000a0ab3 1 21 00000000 0 00000000
jal 8 0000019c 00800b6f 1 22 000001a0 1 000001a4
jal_shadow 9 000001a0 00100b93 0 0 00000000 0 00000000
read_link a 000001a4 000b0c33 1 24 000001a0 0 00000000
jalr b 000001a8 20050ce7 1 25 000001ac 1 000002a0
jalr_shadow c 000001ac 00100b93 0 0 00000000 0 00000000
read_x23 d 000002a0 019b8d33 1 26 000001ac 0 00000000

// File: src.f
ieu_pkg.sv
ieu_regfile.sv
ieu_decode.sv
ieu_ex.sv
ieu_result.sv
ieu_top.sv
ieu_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the integer execution unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module ieu_tb -o ieu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ieu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== PASS ===" "$LOG"; then
    exit 0
fi
exit 1
